// File: source/bch_gf_pkg.sv
package bch_gf_pkg;

  // ------------------------------
  // field constants
  // ------------------------------

  localparam int gf_m      = 4;
  localparam int gf_n_max  = 2**gf_m - 1;
  // x^4 + x + 1, primitive over gf(2)
  localparam int gf_irrpol = 19;

  typedef logic [gf_m-1:0] gf_t;
  typedef gf_t [2**gf_m-1:0] gf_rom_t;

  // ------------------------------
  // table generation
  // ------------------------------

  // alpha^i for i = 0 .. n_max-1, last entry stays zero
  function automatic gf_rom_t gf_gen_alpha_to();
    gf_rom_t       rom;
    logic [gf_m:0] v;
    rom = '0;
    v   = 1;
    for (int i = 0; i < gf_n_max; i++) begin
      rom[i] = v[gf_m-1:0];
      v      = v << 1;
      if (v[gf_m]) begin
        v = v ^ (gf_m+1)'(gf_irrpol);
      end
    end
    return rom;
  endfunction

  // inverse map, log of zero left as zero
  function automatic gf_rom_t gf_gen_index_of(gf_rom_t alpha_to);
    gf_rom_t rom;
    rom = '0;
    for (int i = 0; i < gf_n_max; i++) begin
      rom[alpha_to[i]] = gf_t'(i);
    end
    return rom;
  endfunction

  localparam gf_rom_t gf_alpha_to_rom = gf_gen_alpha_to();
  localparam gf_rom_t gf_index_of_rom = gf_gen_index_of(gf_alpha_to_rom);

  // ------------------------------
  // arithmetic
  // ------------------------------

  // shift and add, reduce on overflow
  function automatic gf_t gf_mult(gf_t a, gf_t b);
    logic [gf_m:0] sh;
    gf_t           acc;
    sh  = {1'b0, a};
    acc = '0;
    for (int i = 0; i < gf_m; i++) begin
      if (b[i]) begin
        acc = acc ^ sh[gf_m-1:0];
      end
      sh = sh << 1;
      if (sh[gf_m]) begin
        sh = sh ^ (gf_m+1)'(gf_irrpol);
      end
    end
    return acc;
  endfunction

  // a * alpha^pw, pw fixed at elaboration
  function automatic gf_t gf_mult_const(gf_t a, int pw);
    return gf_mult(a, gf_alpha_to_rom[pw % gf_n_max]);
  endfunction

  // inverse through log table, zero maps to zero
  function automatic gf_t gf_inv(gf_t a);
    if (a == '0) begin
      return '0;
    end
    return gf_alpha_to_rom[(gf_n_max - int'(gf_index_of_rom[a])) % gf_n_max];
  endfunction

endpackage

// File: source/bch_code_pkg.sv
package bch_code_pkg;
  import bch_gf_pkg::*;

  // ------------------------------
  // code constants
  // ------------------------------

  localparam int code_n    = 15;
  localparam int code_k    = 5;
  localparam int code_t    = 3;
  // one credit per buffer slot
  localparam int buf_slots = 2;

  typedef logic [3:0] bit_idx_t;
  typedef logic       slot_t;

  // serial input, highest degree first
  typedef struct packed {
    logic val;
    logic sop;
    logic eop;
    logic dat;
  } rx_bit_t;

  // syn[j] holds S_j = r(alpha^j)
  typedef struct packed {
    logic                    val;
    slot_t                   slot;
    gf_t [1:2*code_t]        syn;
  } synd_t;

  // coef[0] is the constant term
  typedef struct packed {
    slot_t                   slot;
    logic                    decfail;
    gf_t [code_t:0]          coef;
  } loc_t;

  typedef struct packed {
    logic     sop;
    logic     val;
    logic     eop;
    logic     eof;
    logic     dat;
    logic     dat_nfixed;
    logic     decfail;
    bit_idx_t biterr;
  } dec_out_t;

  typedef enum logic [1:0] {
    bm_idle,
    bm_calc,
    bm_done
  } bm_state_e;

endpackage

// File: source/bch_syndrome.sv
module bch_syndrome
  import bch_gf_pkg::*;
  import bch_code_pkg::*;
(
  input  logic    iclk,
  input  logic    ireset,
  input  rx_bit_t rx,
  input  slot_t   wslot,
  output synd_t   synd
);

  // one accumulator per syndrome
  gf_t [1:2*code_t] acc;
  logic             synd_val;
  slot_t            slot_q;

  // ------------------------------
  // horner accumulation
  // ------------------------------

  // acc_j = acc_j * alpha^j + bit, first bit is degree n-1
  always_ff @(posedge iclk) begin
    if (rx.val) begin
      for (int j = 1; j <= 2*code_t; j++) begin
        if (rx.sop) begin
          // fresh frame, previous value dropped
          acc[j] <= gf_t'(rx.dat);
        end
        else begin
          acc[j] <= gf_mult_const(acc[j], j) ^ gf_t'(rx.dat);
        end
      end
      // slot tag taken while the first bit is written
      if (rx.sop) begin
        slot_q <= wslot;
      end
    end
  end

  // ------------------------------
  // output strobe
  // ------------------------------

  // one cycle after the eop bit, acc holds the final values
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      synd_val <= 1'b0;
    end
    else begin
      synd_val <= rx.val & rx.eop;
    end
  end

  // values hold through the strobe cycle even on back-to-back frames
  assign synd = '{
    val  : synd_val,
    slot : slot_q,
    syn  : acc
  };

endmodule

// File: source/bch_berlekamp.sv
module bch_berlekamp
  import bch_gf_pkg::*;
  import bch_code_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  synd_t synd,
  output loc_t  loc,
  output logic  loc_val,
  input  logic  loc_ready
);

  bm_state_e        state;
  logic             start;

  gf_t [1:2*code_t] sreg;
  // current locator and x^m * previous locator
  gf_t [code_t:0]   c;
  gf_t [code_t:0]   bx;
  gf_t [code_t:0]   c_upd;
  // last nonzero discrepancy
  gf_t              b;
  gf_t              d;
  gf_t              dk;
  logic [2:0]       len;
  // iteration index, 0 .. 2t-1
  logic [2:0]       cnt;
  slot_t            slot_q;

  // new syndromes accepted when idle or while handing off
  assign start = synd.val & ((state == bm_idle) | ((state == bm_done) & loc_ready));

  // ------------------------------
  // discrepancy and update terms
  // ------------------------------

  // d = sum c_i * S_(cnt+1-i)
  always_comb begin
    d = '0;
    for (int i = 0; i <= code_t; i++) begin
      if (i <= int'(cnt)) begin
        d = d ^ gf_mult(c[i], sreg[int'(cnt) + 1 - i]);
      end
    end
  end

  // c - (d/b) * x^m * B
  always_comb begin
    dk = gf_mult(d, gf_inv(b));
    for (int i = 0; i <= code_t; i++) begin
      c_upd[i] = c[i] ^ gf_mult(dk, bx[i]);
    end
  end

  // ------------------------------
  // fsm
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= bm_idle;
    end
    else begin
      case (state)
        bm_idle : if (start) state <= bm_calc;
        // one iteration per syndrome
        bm_calc : if (cnt == 3'(2*code_t - 1)) state <= bm_done;
        bm_done : if (loc_ready) state <= start ? bm_calc : bm_idle;
        default : state <= bm_idle;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (start) begin
      sreg   <= synd.syn;
      slot_q <= synd.slot;
      c      <= '{0: gf_t'(1), default: '0};
      bx     <= '{1: gf_t'(1), default: '0};
      b      <= gf_t'(1);
      len    <= '0;
      cnt    <= '0;
    end
    else if (state == bm_calc) begin
      cnt <= cnt + 3'd1;
      if (d != '0) begin
        c <= c_upd;
        if ({len, 1'b0} <= {1'b0, cnt}) begin
          // register length grows, old locator becomes B
          len <= cnt + 3'd1 - len;
          b   <= d;
          bx  <= c << gf_m;
        end
        else begin
          bx <= bx << gf_m;
        end
      end
      else begin
        bx <= bx << gf_m;
      end
    end
  end

  // more than t errors cannot be located
  assign loc = '{
    slot    : slot_q,
    decfail : (len > 3'(code_t)),
    coef    : c
  };

  assign loc_val = (state == bm_done);

endmodule

// File: source/bch_codeword_buffer.sv
module bch_codeword_buffer
  import bch_code_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  rx_bit_t  rx,
  output slot_t    wslot,
  input  bit_idx_t ram_addr,
  input  slot_t    ram_slot,
  output logic     ram_data,
  input  logic     slot_free,
  output logic     credit
);

  // one codeword per slot, bit 0 received first
  logic [code_n-1:0] mem [buf_slots];
  bit_idx_t          waddr;
  bit_idx_t          wa;

  // sop bit always lands at address 0
  assign wa = rx.sop ? '0 : waddr;

  // ------------------------------
  // write pointer and credits
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      waddr  <= '0;
      wslot  <= '0;
      credit <= 1'b0;
    end
    else begin
      credit <= slot_free;
      if (rx.val) begin
        waddr <= wa + 1'b1;
        // next frame goes to the other slot
        if (rx.eop) begin
          wslot <= ~wslot;
        end
      end
    end
  end

  // ------------------------------
  // bit ram
  // ------------------------------

  // read port registered, one cycle latency
  always_ff @(posedge iclk) begin
    if (rx.val) begin
      mem[wslot][wa] <= rx.dat;
    end
    ram_data <= mem[ram_slot][ram_addr];
  end

endmodule

// File: source/bch_chien_search.sv
module bch_chien_search
  import bch_gf_pkg::*;
  import bch_code_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  loc_t     loc,
  input  logic     loc_val,
  output logic     loc_ready,
  output bit_idx_t ram_addr,
  output slot_t    ram_slot,
  input  logic     ram_data,
  output logic     slot_free,
  output dec_out_t out
);

  logic           start;
  logic           en;
  bit_idx_t       cnt;
  logic           cnt_last;
  // stage 0 marks, straight from the counter
  logic           tick_sop;
  logic           tick_eop;
  logic           tick_eof;
  // stages 1 and 2
  logic [1:0]     val_line;
  logic [1:0]     sop_line;
  logic [1:0]     eop_line;
  logic [1:0]     eof_line;

  gf_t [code_t:0] lm;
  gf_t            lsum;
  logic           zero_q;
  bit_idx_t       loc_deg;
  // taken at start, moved on at the last step
  bit_idx_t       deg_tick;
  bit_idx_t       deg_tack;
  logic           fail_tick;
  logic           fail_tack;
  bit_idx_t       err_cnt;
  bit_idx_t       err_next;
  logic           dat_q;
  logic           nfixed_q;
  logic           decfail_q;
  bit_idx_t       biterr_q;

  // ------------------------------
  // control
  // ------------------------------

  assign cnt_last  = (cnt == bit_idx_t'(code_n - 1));
  assign loc_ready = ~en | cnt_last;
  assign start     = loc_val & loc_ready;

  assign tick_sop  = en & (cnt == '0);
  assign tick_eop  = en & (cnt == bit_idx_t'(code_k - 1));
  assign tick_eof  = en & cnt_last;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      en       <= 1'b0;
      cnt      <= '0;
      val_line <= '0;
      sop_line <= '0;
      eop_line <= '0;
      eof_line <= '0;
    end
    else begin
      if (start) begin
        en <= 1'b1;
      end
      else if (en & cnt_last) begin
        en <= 1'b0;
      end
      if (start) begin
        cnt <= '0;
      end
      else if (en) begin
        cnt <= cnt + 1'b1;
      end
      val_line <= {val_line[0], en};
      sop_line <= {sop_line[0], tick_sop};
      eop_line <= {eop_line[0], tick_eop};
      eof_line <= {eof_line[0], tick_eof};
    end
  end

  // ram follows the step counter
  assign ram_addr  = cnt;
  // last bit of the slot read on this cycle
  assign slot_free = tick_eof;

  // ------------------------------
  // locator evaluation
  // ------------------------------

  // highest nonzero coefficient
  always_comb begin
    loc_deg = '0;
    for (int i = 1; i <= code_t; i++) begin
      if (loc.coef[i] != '0) begin
        loc_deg = bit_idx_t'(i);
      end
    end
  end

  always_comb begin
    lsum = '0;
    for (int i = 0; i <= code_t; i++) begin
      lsum = lsum ^ lm[i];
    end
  end

  // step s tests alpha^(s+1), the root for degree n-1-s
  always_ff @(posedge iclk) begin
    if (start) begin
      ram_slot  <= loc.slot;
      fail_tick <= loc.decfail;
      deg_tick  <= loc_deg;
      for (int i = 0; i <= code_t; i++) begin
        lm[i] <= gf_mult_const(loc.coef[i], i);
      end
    end
    else if (en) begin
      for (int i = 1; i <= code_t; i++) begin
        lm[i] <= gf_mult_const(lm[i], i);
      end
    end
    if (en & cnt_last) begin
      fail_tack <= fail_tick;
      deg_tack  <= deg_tick;
    end
    if (en) begin
      zero_q <= (lsum == '0);
    end
  end

  // ------------------------------
  // correction and statistics
  // ------------------------------

  assign err_next = (sop_line[0] ? '0 : err_cnt) + bit_idx_t'(zero_q);

  always_ff @(posedge iclk) begin
    // zero_q and ram_data line up here
    if (val_line[0]) begin
      dat_q    <= ram_data ^ zero_q;
      nfixed_q <= ram_data;
      err_cnt  <= err_next;
    end
    if (eof_line[0]) begin
      biterr_q  <= err_next;
      // flips must match the locator degree
      decfail_q <= fail_tack | (err_next != deg_tack);
    end
  end

  assign out = '{
    sop        : sop_line[1],
    val        : val_line[1],
    eop        : eop_line[1],
    eof        : eof_line[1],
    dat        : dat_q,
    dat_nfixed : nfixed_q,
    decfail    : decfail_q,
    biterr     : biterr_q
  };

endmodule

// File: source/bch_decoder.sv
module bch_decoder
  import bch_code_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  rx_bit_t  rx,
  output logic     credit,
  output dec_out_t out
);

  // ------------------------------
  // inter-block wires
  // ------------------------------

  slot_t    wslot;
  synd_t    synd;
  loc_t     loc;
  logic     loc_val;
  logic     loc_ready;
  bit_idx_t ram_addr;
  slot_t    ram_slot;
  logic     ram_data;
  logic     slot_free;

  // syndromes straight off the serial stream
  bch_syndrome i_syndrome (
    .iclk   (iclk),
    .ireset (ireset),
    .rx     (rx),
    .wslot  (wslot),
    .synd   (synd)
  );

  bch_berlekamp i_berlekamp (
    .iclk      (iclk),
    .ireset    (ireset),
    .synd      (synd),
    .loc       (loc),
    .loc_val   (loc_val),
    .loc_ready (loc_ready)
  );

  // received bits wait here for their locator
  bch_codeword_buffer i_buffer (
    .iclk      (iclk),
    .ireset    (ireset),
    .rx        (rx),
    .wslot     (wslot),
    .ram_addr  (ram_addr),
    .ram_slot  (ram_slot),
    .ram_data  (ram_data),
    .slot_free (slot_free),
    .credit    (credit)
  );

  bch_chien_search i_chien (
    .iclk      (iclk),
    .ireset    (ireset),
    .loc       (loc),
    .loc_val   (loc_val),
    .loc_ready (loc_ready),
    .ram_addr  (ram_addr),
    .ram_slot  (ram_slot),
    .ram_data  (ram_data),
    .slot_free (slot_free),
    .out       (out)
  );

endmodule

// File: dv/bch_decoder_assertions.sv
module bch_decoder_assertions
  import bch_code_pkg::*;
(
  input logic     iclk,
  input logic     ireset,
  input rx_bit_t  rx,
  input logic     credit,
  input dec_out_t out
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int par_bits = code_n - code_k;
  // g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
  localparam logic [par_bits:0] gen_poly = 11'h537;

  // read back by the testbench at the end of the run
  int fail_cnt = 0;

  logic [par_bits-1:0] rem;
  logic [par_bits:0]   rem_shift;
  logic [par_bits-1:0] rem_next;
  bit_idx_t            diff;
  bit_idx_t            diff_next;
  logic [4:0]          pos;
  logic [4:0]          cur_pos;
  logic                busy;
  int                  started;
  int                  returned;
  logic                seen_input;

  // ------------------------------
  // output stream trackers
  // ------------------------------

  // remainder of the output word mod g(x), zero for any codeword
  always_comb begin
    rem_shift = {(out.sop ? '0 : rem), out.dat};
    rem_next  = rem_shift[par_bits] ? (rem_shift[par_bits-1:0] ^ gen_poly[par_bits-1:0])
                                    : rem_shift[par_bits-1:0];
    diff_next = (out.sop ? '0 : diff) + bit_idx_t'(out.dat != out.dat_nfixed);
    cur_pos   = out.sop ? '0 : pos;
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rem        <= '0;
      diff       <= '0;
      pos        <= '0;
      busy       <= 1'b0;
      started    <= 0;
      returned   <= 0;
      seen_input <= 1'b0;
    end
    else begin
      if (out.val) begin
        rem  <= rem_next;
        diff <= diff_next;
        pos  <= cur_pos + 5'd1;
        busy <= ~out.eof;
      end
      if (rx.val) begin
        seen_input <= 1'b1;
      end
      // frames entering vs slots handed back
      if (rx.val & rx.sop) begin
        started <= started + 1;
      end
      if (credit) begin
        returned <= returned + 1;
      end
    end
  end

  // ------------------------------
  // properties
  // ------------------------------

  codeword_out: assert property (@(posedge iclk) disable iff (ireset)
    out.eof && !out.decfail |-> rem_next == '0)
    else begin
      $error("frame accepted without decfail is not a codeword");
      fail_cnt++;
    end

  biterr_match: assert property (@(posedge iclk) disable iff (ireset)
    out.eof |-> out.biterr == diff_next && out.biterr <= bit_idx_t'(code_t))
    else begin
      $error("biterr disagrees with flipped bits or exceeds t");
      fail_cnt++;
    end

  // no gaps, no val outside a frame
  frame_val: assert property (@(posedge iclk) disable iff (ireset)
    out.val == (busy || out.sop))
    else begin
      $error("output val broken inside or outside a frame");
      fail_cnt++;
    end

  frame_overlap: assert property (@(posedge iclk) disable iff (ireset)
    out.sop |-> !busy)
    else begin
      $error("output sop arrived before the previous eof");
      fail_cnt++;
    end

  frame_marks: assert property (@(posedge iclk) disable iff (ireset)
    out.val |-> out.eop == (cur_pos == 5'(code_k - 1)) &&
                out.eof == (cur_pos == 5'(code_n - 1)))
    else begin
      $error("eop or eof at the wrong bit of the frame");
      fail_cnt++;
    end

  credit_excess: assert property (@(posedge iclk) disable iff (ireset)
    credit |-> returned < started)
    else begin
      $error("more credits returned than frames sent");
      fail_cnt++;
    end

  credit_overrun: assert property (@(posedge iclk) disable iff (ireset)
    rx.val && rx.sop |-> started - returned < buf_slots)
    else begin
      $error("frame started without a free credit");
      fail_cnt++;
    end

  // quiet until the first input bit
  idle_quiet: assert property (@(posedge iclk) disable iff (ireset)
    !seen_input |-> !credit && !out.val)
    else begin
      $error("credit or output active before any input");
      fail_cnt++;
    end

endmodule

bind bch_decoder bch_decoder_assertions i_checks (
  .iclk   (iclk),
  .ireset (ireset),
  .rx     (rx),
  .credit (credit),
  .out    (out)
);

// File: dv/bch_decoder_tb.sv
module bch_decoder_tb
  import bch_code_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int par_bits = code_n - code_k;
  localparam logic [par_bits:0] gen_poly = 11'h537;
  // frames over all tests, sizes the watchdog
  localparam int total_frames    = 38;
  localparam int watchdog_cycles = total_frames * 40 + 200;

  typedef struct packed {
    logic [code_n-1:0] cw;
    bit_idx_t          nerr;
    // data and count known in advance
    logic              exact;
  } expect_t;

  logic              iclk = 1'b0;
  logic              ireset;
  rx_bit_t           rx;
  logic              credit;
  dec_out_t          out;

  expect_t           exp_q[$];
  int                frames_sent  = 0;
  int                credits_back = 0;
  int                frames_done  = 0;
  int                tb_fails     = 0;
  int                tests_passed = 0;
  int                tests_failed = 0;
  logic [code_n-1:0] got_cw;

  always #5 iclk = ~iclk;

  bch_decoder i_dut (
    .iclk   (iclk),
    .ireset (ireset),
    .rx     (rx),
    .credit (credit),
    .out    (out)
  );

  // ------------------------------
  // models
  // ------------------------------

  // systematic, data in the top five bits
  function automatic logic [code_n-1:0] encode(logic [code_k-1:0] data);
    logic [code_n-1:0] r;
    r = {data, {par_bits{1'b0}}};
    for (int i = code_n - 1; i >= par_bits; i--) begin
      if (r[i]) begin
        r[i -: par_bits+1] = r[i -: par_bits+1] ^ gen_poly;
      end
    end
    return {data, r[par_bits-1:0]};
  endfunction

  // nerr distinct random positions
  function automatic logic [code_n-1:0] error_mask(int nerr);
    logic [code_n-1:0] m;
    int                p;
    m = '0;
    while ($countones(m) < nerr) begin
      p    = int'($urandom % code_n);
      m[p] = 1'b1;
    end
    return m;
  endfunction

  function automatic int error_total();
    return tb_fails + i_dut.i_checks.fail_cnt;
  endfunction

  // ------------------------------
  // source with credit counting
  // ------------------------------

  always @(posedge iclk) begin
    if (!ireset && credit) begin
      credits_back <= credits_back + 1;
    end
  end

  // called 1 ns after an edge, returns 1 ns after an edge
  task automatic send_frame(logic [code_n-1:0] cw, logic [code_n-1:0] emask, logic exact);
    logic [code_n-1:0] word;
    word = cw ^ emask;
    while (frames_sent - credits_back >= buf_slots) begin
      @(posedge iclk);
      #1;
    end
    exp_q.push_back('{cw: cw, nerr: bit_idx_t'($countones(emask)), exact: exact});
    frames_sent++;
    for (int i = 0; i < code_n; i++) begin
      rx.val = 1'b1;
      rx.sop = (i == 0);
      rx.eop = (i == code_n - 1);
      rx.dat = word[code_n-1-i];
      @(posedge iclk);
      #1;
    end
    rx = '0;
  endtask

  task automatic run_test(string name, int nframes, int min_err, int max_err,
                          logic exact, int gap);
    int fails_before;
    int nerr;
    int fails;
    fails_before = error_total();
    for (int f = 0; f < nframes; f++) begin
      nerr = min_err + int'($urandom % (max_err - min_err + 1));
      send_frame(encode(code_k'($urandom)), error_mask(nerr), exact);
      repeat (gap) begin
        @(posedge iclk);
        #1;
      end
    end
    // drained once every frame has come out
    wait (frames_done == frames_sent);
    fails = error_total() - fails_before;
    if (fails == 0) begin
      tests_passed++;
    end
    else begin
      tests_failed++;
    end
    $display("test %s: %0d frames, %0d check failures, %s", name, nframes, fails,
             (fails == 0) ? "pass" : "fail");
  endtask

  // ------------------------------
  // output monitor
  // ------------------------------

  always @(posedge iclk) begin
    expect_t e;
    if (!ireset && out.val) begin
      got_cw = {got_cw[code_n-2:0], out.dat};
      if (out.eof) begin
        if (exp_q.size() == 0) begin
          $display("output frame arrived with no frame outstanding");
          tb_fails++;
        end
        else begin
          e = exp_q.pop_front();
          if (e.exact) begin
            assert (got_cw == e.cw) else begin
              $display("** Error: out.dat frame %0d got 0x%h expected 0x%h",
                       frames_done, got_cw, e.cw);
              tb_fails++;
            end
            assert (out.biterr == e.nerr) else begin
              $display("** Error: out.biterr frame %0d got 0x%h expected 0x%h",
                       frames_done, out.biterr, e.nerr);
              tb_fails++;
            end
            assert (!out.decfail) else begin
              $display("** Error: out.decfail frame %0d got 0x%h expected 0x%h",
                       frames_done, out.decfail, 1'b0);
              tb_fails++;
            end
          end
          frames_done <= frames_done + 1;
        end
      end
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(32'hcb2330e5));
    ireset = 1'b1;
    rx     = '0;
    repeat (4) @(posedge iclk);
    #1;
    ireset = 1'b0;
    // idle stretch, nothing may come out
    repeat (20) @(posedge iclk);
    #1;
    run_test("clean", 4, 0, 0, 1'b1, 10);
    run_test("correctable", 8, 1, code_t, 1'b1, 10);
    run_test("overloaded", 6, code_t + 1, 7, 1'b0, 10);
    run_test("back_to_back", 20, 0, code_t, 1'b1, 0);
    $display("tests passed %0d, tests failed %0d, check failures %0d",
             tests_passed, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("ALL TESTS PASSED");
    end
    else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // frames times 40 cycles plus margin
  initial begin
    #(watchdog_cycles * 10);
    $display("watchdog expired after %0d cycles, decoder stopped producing frames",
             watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: compile.f
source/bch_gf_pkg.sv
source/bch_code_pkg.sv
source/bch_syndrome.sv
source/bch_berlekamp.sv
source/bch_codeword_buffer.sv
source/bch_chien_search.sv
source/bch_decoder.sv
dv/bch_decoder_assertions.sv
dv/bch_decoder_tb.sv

// File: Makefile
TOP = bch_decoder_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f compile.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
